//--- hdl/rx_pkg.sv
package rx_pkg;

    // ------------------------------------------------------------
    // widths with a meaning
    // ------------------------------------------------------------

    // Q in the upper half, I in the lower half
    typedef logic [31:0] sample_t;

    // phase and CFO increment, read as two's complement
    typedef logic [19:0] phase_t;

    typedef logic [31:0] sample_id_t;
    typedef logic [1:0]  n_id_2_t;
    typedef logic [9:0]  n_id_t;
    typedef logic [2:0]  ibar_t;
    typedef logic [7:0]  llr_t;
    typedef logic [1:0]  llr_user_t;
    typedef logic [15:0] missed_t;
    typedef logic [3:0]  reg_addr_t;

    typedef enum logic [1:0] {
        SYNC_SEARCH    = 2'd0,
        SYNC_PSS_FOUND = 2'd1,
        SYNC_LOCKED    = 2'd2
    } sync_state_t;

    // llr channel tag carried by PBCH soft bits
    localparam llr_user_t LLR_USER_PBCH = 2'd1;

    // ------------------------------------------------------------
    // status register map
    // ------------------------------------------------------------
    localparam reg_addr_t REG_STATE      = 4'd0;
    localparam reg_addr_t REG_N_ID_2     = 4'd1;
    localparam reg_addr_t REG_N_ID       = 4'd2;
    localparam reg_addr_t REG_IBAR       = 4'd3;
    localparam reg_addr_t REG_MISSED     = 4'd4;
    localparam reg_addr_t REG_PHASE      = 4'd5;
    localparam reg_addr_t REG_SAMPLE_ID  = 4'd6;
    localparam reg_addr_t REG_FIFO_LEVEL = 4'd7;

endpackage

//--- hdl/rx_sync_ctrl.sv
module rx_sync_ctrl #(
    parameter int MAX_MISSED_SSBS = 3
) (
    input  logic                clk_i,
    input  logic                reset_ni,

    input  logic                pss_valid_i,
    input  rx_pkg::n_id_2_t     n_id_2_i,
    input  logic                n_id_valid_i,
    input  rx_pkg::n_id_t       n_id_i,
    input  rx_pkg::ibar_t       ibar_i,
    input  logic                ssb_tick_i,

    output rx_pkg::sync_state_t state_o,
    output rx_pkg::n_id_2_t     n_id_2_o,
    output rx_pkg::n_id_t       n_id_o,
    output rx_pkg::ibar_t       ibar_o,
    output rx_pkg::missed_t     missed_o,
    output logic                cfo_track_en_o,
    output logic                llr_store_en_o
);
    import rx_pkg::*;

    localparam int RUN_W = $clog2(MAX_MISSED_SSBS + 1);

    sync_state_t      state_q;
    n_id_2_t          n_id_2_q;
    n_id_t            n_id_q;
    ibar_t            ibar_q;
    missed_t          missed_q;
    logic [RUN_W-1:0] run_cnt;
    logic             pss_seen;
    logic             ssb_missed;

    // a PSS arriving in the tick cycle still belongs to that period
    assign ssb_missed = ssb_tick_i && !pss_seen && !pss_valid_i;

    // ------------------------------------------------------------
    // sync FSM and missed-SSB bookkeeping
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q  <= SYNC_SEARCH;
            n_id_2_q <= '0;
            n_id_q   <= '0;
            ibar_q   <= '0;
            missed_q <= '0;
            run_cnt  <= '0;
        end else begin
            case (state_q)
                SYNC_SEARCH: begin
                    if (pss_valid_i) begin
                        n_id_2_q <= n_id_2_i;
                        state_q  <= SYNC_PSS_FOUND;
                    end
                end
                SYNC_PSS_FOUND: begin
                    if (n_id_valid_i) begin
                        n_id_q  <= n_id_i;
                        ibar_q  <= ibar_i;
                        state_q <= SYNC_LOCKED;
                    end
                end
                SYNC_LOCKED: begin
                    if (ssb_missed) begin
                        missed_q <= missed_q + 1'b1;
                        if (run_cnt == RUN_W'(MAX_MISSED_SSBS - 1)) begin
                            // too many in a row, start over
                            run_cnt <= '0;
                            state_q <= SYNC_SEARCH;
                        end else begin
                            run_cnt <= run_cnt + 1'b1;
                        end
                    end else if (ssb_tick_i) begin
                        run_cnt <= '0;
                    end
                end
                default: state_q <= SYNC_SEARCH;
            endcase
        end
    end

    // PSS seen within the current SSB period, only tracked while locked
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pss_seen <= 1'b0;
        end else if (state_q != SYNC_LOCKED || ssb_tick_i) begin
            pss_seen <= 1'b0;
        end else if (pss_valid_i) begin
            pss_seen <= 1'b1;
        end
    end

    assign state_o        = state_q;
    assign n_id_2_o       = n_id_2_q;
    assign n_id_o         = n_id_q;
    assign ibar_o         = ibar_q;
    assign missed_o       = missed_q;
    assign cfo_track_en_o = (state_q != SYNC_SEARCH);
    assign llr_store_en_o = (state_q == SYNC_LOCKED);

endmodule

//--- hdl/cfo_phase_tracker.sv
module cfo_phase_tracker (
    input  logic               clk_i,
    input  logic               reset_ni,

    input  logic               track_en_i,
    input  logic               cfo_manual_i,
    input  logic               cfo_valid_i,
    input  rx_pkg::phase_t     cfo_inc_i,
    input  logic               sample_valid_i,

    output rx_pkg::phase_t     phase_o,
    output rx_pkg::sample_id_t sample_id_o
);
    import rx_pkg::*;

    phase_t     cfo_inc_q;
    phase_t     phase_q;
    sample_id_t sample_id_q;

    // ------------------------------------------------------------
    // increment and phase accumulators
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cfo_inc_q <= '0;
            phase_q   <= '0;
        end else if (cfo_manual_i) begin
            // manual mode, no correction applied
            cfo_inc_q <= '0;
            phase_q   <= '0;
        end else begin
            // estimates are relative to the previous one
            if (cfo_valid_i && track_en_i) begin
                cfo_inc_q <= cfo_inc_q - cfo_inc_i;
            end
            // wraps modulo 2^20
            if (sample_valid_i) begin
                phase_q <= phase_q + cfo_inc_q;
            end
        end
    end

    // running sample id, counts in every mode
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_id_q <= '0;
        end else if (sample_valid_i) begin
            sample_id_q <= sample_id_q + 1'b1;
        end
    end

    assign phase_o     = phase_q;
    assign sample_id_o = sample_id_q;

endmodule

//--- hdl/pbch_llr_fifo.sv
module pbch_llr_fifo #(
    parameter int FIFO_DEPTH   = 16,
    parameter int LINK_CREDITS = 4
) (
    input  logic              clk_i,
    input  logic              reset_ni,

    input  logic              store_en_i,
    input  logic              llr_valid_i,
    input  rx_pkg::llr_t      llr_i,
    input  rx_pkg::llr_user_t llr_user_i,

    input  logic              credit_i,
    output logic              pbch_valid_o,
    output rx_pkg::llr_t      pbch_llr_o,
    output logic [7:0]        level_o
);
    import rx_pkg::*;

    localparam int PTR_W    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CREDIT_W = $clog2(LINK_CREDITS + 1);

    llr_t                mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [7:0]          count;
    logic [CREDIT_W-1:0] credit_cnt;
    logic                full;
    logic                empty;
    logic                push;
    logic                send;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == 8'(FIFO_DEPTH));
    assign empty = (count == '0);

    // only PBCH soft bits are kept, and only once locked
    assign push = store_en_i && llr_valid_i && (llr_user_i == LLR_USER_PBCH) && !full;
    assign send = !empty && (credit_cnt != '0);

    // ------------------------------------------------------------
    // circular buffer
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= llr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (send) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------------
    // credit counter and output register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            credit_cnt   <= CREDIT_W'(LINK_CREDITS);
            pbch_valid_o <= 1'b0;
        end else begin
            case ({send, credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            pbch_valid_o <= send;
        end
    end

    always_ff @(posedge clk_i) begin
        if (send) begin
            pbch_llr_o <= mem[rd_ptr];
        end
    end

    assign level_o = count;

endmodule

//--- hdl/rx_status_regs.sv
module rx_status_regs (
    input  logic                clk_i,
    input  logic                reset_ni,

    input  logic                rd_en_i,
    input  rx_pkg::reg_addr_t   rd_addr_i,

    input  rx_pkg::sync_state_t state_i,
    input  rx_pkg::n_id_2_t     n_id_2_i,
    input  rx_pkg::n_id_t       n_id_i,
    input  rx_pkg::ibar_t       ibar_i,
    input  rx_pkg::missed_t     missed_i,
    input  rx_pkg::phase_t      phase_i,
    input  rx_pkg::sample_id_t  sample_id_i,
    input  logic [7:0]          level_i,

    output logic                rd_valid_o,
    output logic [31:0]         rd_data_o
);
    import rx_pkg::*;

    logic [31:0] rd_mux;

    // address decode, everything zero-extended
    always_comb begin
        case (rd_addr_i)
            REG_STATE:      rd_mux = 32'(state_i);
            REG_N_ID_2:     rd_mux = 32'(n_id_2_i);
            REG_N_ID:       rd_mux = 32'(n_id_i);
            REG_IBAR:       rd_mux = 32'(ibar_i);
            REG_MISSED:     rd_mux = 32'(missed_i);
            REG_PHASE:      rd_mux = 32'(phase_i);
            REG_SAMPLE_ID:  rd_mux = sample_id_i;
            REG_FIFO_LEVEL: rd_mux = 32'(level_i);
            default:        rd_mux = '0;
        endcase
    end

    // ------------------------------------------------------------
    // one-cycle read response
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= rd_mux;
        end
    end

endmodule

//--- hdl/rx_status_top.sv
module rx_status_top #(
    parameter int FIFO_DEPTH      = 16,
    parameter int MAX_MISSED_SSBS = 3,
    parameter int LINK_CREDITS    = 4
) (
    input  logic                clk_i,
    input  logic                reset_ni,

    // samples, only the strobe advances the counters
    input  rx_pkg::sample_t     sample_i,
    input  logic                sample_valid_i,

    input  logic                pss_valid_i,
    input  rx_pkg::n_id_2_t     n_id_2_i,
    input  logic                n_id_valid_i,
    input  rx_pkg::n_id_t       n_id_i,
    input  rx_pkg::ibar_t       ibar_i,
    input  logic                ssb_tick_i,

    input  logic                cfo_valid_i,
    input  rx_pkg::phase_t      cfo_inc_i,
    input  logic                cfo_manual_i,

    input  logic                llr_valid_i,
    input  rx_pkg::llr_t        llr_i,
    input  rx_pkg::llr_user_t   llr_user_i,
    input  logic                credit_i,
    output logic                pbch_valid_o,
    output rx_pkg::llr_t        pbch_llr_o,

    input  logic                rd_en_i,
    input  rx_pkg::reg_addr_t   rd_addr_i,
    output logic                rd_valid_o,
    output logic [31:0]         rd_data_o,

    output rx_pkg::sync_state_t sync_state_o
);
    import rx_pkg::*;

    sync_state_t sync_state;
    n_id_2_t     n_id_2;
    n_id_t       n_id;
    ibar_t       ibar;
    missed_t     missed;
    phase_t      phase;
    sample_id_t  sample_id;
    logic [7:0]  fifo_level;
    logic        cfo_track_en;
    logic        llr_store_en;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    rx_sync_ctrl #(
        .MAX_MISSED_SSBS(MAX_MISSED_SSBS)
    ) u_rx_sync_ctrl (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .pss_valid_i    (pss_valid_i),
        .n_id_2_i       (n_id_2_i),
        .n_id_valid_i   (n_id_valid_i),
        .n_id_i         (n_id_i),
        .ibar_i         (ibar_i),
        .ssb_tick_i     (ssb_tick_i),
        .state_o        (sync_state),
        .n_id_2_o       (n_id_2),
        .n_id_o         (n_id),
        .ibar_o         (ibar),
        .missed_o       (missed),
        .cfo_track_en_o (cfo_track_en),
        .llr_store_en_o (llr_store_en)
    );

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------
    cfo_phase_tracker u_cfo_phase_tracker (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .track_en_i     (cfo_track_en),
        .cfo_manual_i   (cfo_manual_i),
        .cfo_valid_i    (cfo_valid_i),
        .cfo_inc_i      (cfo_inc_i),
        .sample_valid_i (sample_valid_i),
        .phase_o        (phase),
        .sample_id_o    (sample_id)
    );

    pbch_llr_fifo #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .LINK_CREDITS (LINK_CREDITS)
    ) u_pbch_llr_fifo (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .store_en_i   (llr_store_en),
        .llr_valid_i  (llr_valid_i),
        .llr_i        (llr_i),
        .llr_user_i   (llr_user_i),
        .credit_i     (credit_i),
        .pbch_valid_o (pbch_valid_o),
        .pbch_llr_o   (pbch_llr_o),
        .level_o      (fifo_level)
    );

    rx_status_regs u_rx_status_regs (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .rd_en_i     (rd_en_i),
        .rd_addr_i   (rd_addr_i),
        .state_i     (sync_state),
        .n_id_2_i    (n_id_2),
        .n_id_i      (n_id),
        .ibar_i      (ibar),
        .missed_i    (missed),
        .phase_i     (phase),
        .sample_id_i (sample_id),
        .level_i     (fifo_level),
        .rd_valid_o  (rd_valid_o),
        .rd_data_o   (rd_data_o)
    );

    assign sync_state_o = sync_state;

endmodule

//--- verification/rx_status_props.sv
module rx_status_props #(
    parameter int FIFO_DEPTH   = 16,
    parameter int LINK_CREDITS = 4
) (
    input logic                clk_i,
    input logic                reset_ni,
    input logic                pbch_valid_i,
    input logic                credit_i,
    input logic [7:0]          level_i,
    input rx_pkg::sync_state_t state_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import rx_pkg::*;

    int unsigned fail_count = 0;
    int          credits_left;

    // link credits left as seen at the FIFO output
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            credits_left <= LINK_CREDITS;
        end else begin
            credits_left <= credits_left - int'(pbch_valid_i) + int'(credit_i);
        end
    end

    // each word leaving the FIFO uses up a granted credit
    a_credit_held: assert property (@(posedge clk_i) disable iff (!reset_ni)
        pbch_valid_i |-> credits_left > 0)
        else begin
            fail_count++;
            $error("PBCH word sent while no link credit was held");
        end

    a_level_bound: assert property (@(posedge clk_i) disable iff (!reset_ni)
        level_i <= 8'(FIFO_DEPTH))
        else begin
            fail_count++;
            $error("FIFO level above its depth");
        end

    // search -> pss found -> locked -> search, nothing else
    a_state_step: assert property (@(posedge clk_i) disable iff (!reset_ni)
        state_i != $past(state_i) |->
            ($past(state_i) == SYNC_SEARCH    && state_i == SYNC_PSS_FOUND) ||
            ($past(state_i) == SYNC_PSS_FOUND && state_i == SYNC_LOCKED) ||
            ($past(state_i) == SYNC_LOCKED    && state_i == SYNC_SEARCH))
        else begin
            fail_count++;
            $error("illegal sync state transition");
        end

endmodule

//--- verification/rx_status_tb.sv
module rx_status_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rx_pkg::*;

    localparam int FIFO_DEPTH      = 16;
    localparam int MAX_MISSED_SSBS = 3;
    localparam int LINK_CREDITS    = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int CFO_UPDATES     = 6;
    localparam int CFO_SAMPLES     = 40;
    localparam int FILTER_LLRS     = 24;
    localparam int FIRST_BATCH     = 10;
    localparam int DRAIN_CYCLES    = 4 * FIFO_DEPTH + 32;
    // rough run length, each LLR takes two cycles, each read three
    localparam int TEST_CYCLES     = 2 * (FILTER_LLRS + FIRST_BATCH + FIFO_DEPTH + 8)
                                     + 2 * CFO_SAMPLES + CFO_UPDATES + 4 * DRAIN_CYCLES + 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 * TEST_CYCLES;

    logic        clk_i          = 1'b0;
    logic        reset_ni       = 1'b0;
    sample_t     sample_i       = '0;
    logic        sample_valid_i = 1'b0;
    logic        pss_valid_i    = 1'b0;
    n_id_2_t     n_id_2_i       = '0;
    logic        n_id_valid_i   = 1'b0;
    n_id_t       n_id_i         = '0;
    ibar_t       ibar_i         = '0;
    logic        ssb_tick_i     = 1'b0;
    logic        cfo_valid_i    = 1'b0;
    phase_t      cfo_inc_i      = '0;
    logic        cfo_manual_i   = 1'b0;
    logic        llr_valid_i    = 1'b0;
    llr_t        llr_i          = '0;
    llr_user_t   llr_user_i     = '0;
    logic        credit_i       = 1'b0;
    logic        rd_en_i        = 1'b0;
    reg_addr_t   rd_addr_i      = '0;
    logic        pbch_valid_o;
    llr_t        pbch_llr_o;
    logic        rd_valid_o;
    logic [31:0] rd_data_o;
    sync_state_t sync_state_o;

    integer seed;
    int     checks        = 0;
    int     errors        = 0;
    int     samples_total = 0;
    int     credits_due   = 0;
    bit     auto_credit   = 1'b0;
    int     assert_fails;
    llr_t   rx_q[$];

    rx_status_top #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .MAX_MISSED_SSBS (MAX_MISSED_SSBS),
        .LINK_CREDITS    (LINK_CREDITS)
    ) u_rx_status_top (.*);

    bind pbch_llr_fifo rx_status_props #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .LINK_CREDITS (LINK_CREDITS)
    ) u_fifo_props (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .pbch_valid_i (pbch_valid_o),
        .credit_i     (credit_i),
        .level_i      (level_o),
        .state_i      (rx_pkg::SYNC_SEARCH)
    );

    bind rx_sync_ctrl rx_status_props u_ctrl_props (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .pbch_valid_i (1'b0),
        .credit_i     (1'b0),
        .level_i      (8'd0),
        .state_i      (state_q)
    );

    always #5 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // PBCH sink, collects words and hands credits back
    // ------------------------------------------------------------
    always @(negedge clk_i) begin
        if (reset_ni && pbch_valid_o) begin
            rx_q.push_back(pbch_llr_o);
            if (auto_credit) credits_due++;
        end
    end

    always @(posedge clk_i) begin
        if (credits_due > 0) begin
            credit_i <= 1'b1;
            credits_due--;
        end else begin
            credit_i <= 1'b0;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic read_reg(input reg_addr_t addr, output logic [31:0] data);
        @(posedge clk_i);
        rd_en_i   <= 1'b1;
        rd_addr_i <= addr;
        @(posedge clk_i);
        rd_en_i <= 1'b0;
        @(negedge clk_i);
        if (!rd_valid_o) begin
            errors++;
            $display("read of address %0d got no response one cycle after the request", addr);
        end
        data = rd_data_o;
    endtask

    task automatic expect_reg(input string name, input reg_addr_t addr,
                              input logic [31:0] expected);
        logic [31:0] data;
        read_reg(addr, data);
        check(name, expected, data);
    endtask

    task automatic pulse_pss(input n_id_2_t id);
        @(posedge clk_i);
        pss_valid_i <= 1'b1;
        n_id_2_i    <= id;
        @(posedge clk_i);
        pss_valid_i <= 1'b0;
    endtask

    task automatic ssb_tick();
        @(posedge clk_i);
        ssb_tick_i <= 1'b1;
        @(posedge clk_i);
        ssb_tick_i <= 1'b0;
    endtask

    task automatic send_llr(input llr_t value, input llr_user_t tag);
        @(posedge clk_i);
        llr_valid_i <= 1'b1;
        llr_i       <= value;
        llr_user_i  <= tag;
        @(posedge clk_i);
        llr_valid_i <= 1'b0;
    endtask

    task automatic drive_samples(input int count);
        repeat (count) begin
            @(posedge clk_i);
            sample_valid_i <= 1'b1;
            sample_i       <= sample_t'($random(seed));
            samples_total++;
        end
        @(posedge clk_i);
        sample_valid_i <= 1'b0;
    endtask

    task automatic return_credits(input int count);
        @(negedge clk_i);
        credits_due += count;
    endtask

    task automatic settle_credits();
        wait (credits_due == 0);
        repeat (2) @(posedge clk_i);
        auto_credit = 1'b0;
    endtask

    task automatic wait_pbch(input int count, input string name);
        int cycles;
        cycles = 0;
        while (rx_q.size() < count && cycles < DRAIN_CYCLES) begin
            @(negedge clk_i);
            cycles++;
        end
        if (rx_q.size() < count) begin
            errors++;
            $display("%s: only %0d of %0d PBCH words came out", name, rx_q.size(), count);
        end
    endtask

    task automatic check_stream(input string name, input llr_t exp_q[$]);
        // idle a little so that extra words would show up
        repeat (8) @(negedge clk_i);
        check({name, " count"}, exp_q.size(), rx_q.size());
        foreach (exp_q[i]) begin
            if (i < rx_q.size()) check({name, " data"}, exp_q[i], rx_q[i]);
        end
        rx_q.delete();
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic test_llr_before_lock();
        repeat (4) send_llr(llr_t'($random(seed)), LLR_USER_PBCH);
        repeat (4) @(posedge clk_i);
        expect_reg("llr_before_lock level", REG_FIFO_LEVEL, 0);
        check("llr_before_lock output", 0, rx_q.size());
    endtask

    task automatic test_lock_sequence();
        pulse_pss(2'd2);
        @(posedge clk_i);
        n_id_valid_i <= 1'b1;
        n_id_i       <= 10'd517;
        ibar_i       <= 3'd5;
        @(posedge clk_i);
        n_id_valid_i <= 1'b0;
        expect_reg("lock state", REG_STATE, SYNC_LOCKED);
        expect_reg("lock n_id_2", REG_N_ID_2, 2);
        expect_reg("lock n_id", REG_N_ID, 517);
        expect_reg("lock ibar", REG_IBAR, 5);
        check("lock state output", SYNC_LOCKED, sync_state_o);
    endtask

    task automatic test_pbch_filter();
        llr_t      exp_q[$];
        llr_t      value;
        llr_user_t tag;
        auto_credit = 1'b1;
        repeat (FILTER_LLRS) begin
            value = llr_t'($random(seed));
            tag   = llr_user_t'({$random(seed)} % 3);
            if (tag == LLR_USER_PBCH) exp_q.push_back(value);
            send_llr(value, tag);
        end
        wait_pbch(exp_q.size(), "pbch_filter");
        check_stream("pbch_filter", exp_q);
        settle_credits();
    endtask

    task automatic test_credit_flow();
        llr_t exp_q[$];
        llr_t value;
        int   level;
        repeat (FIRST_BATCH) begin
            value = llr_t'($random(seed));
            exp_q.push_back(value);
            send_llr(value, LLR_USER_PBCH);
        end
        wait_pbch(LINK_CREDITS, "credit_flow first");
        repeat (8) @(negedge clk_i);
        check("credit_flow sent", LINK_CREDITS, rx_q.size());
        level = FIRST_BATCH - LINK_CREDITS;
        expect_reg("credit_flow level", REG_FIFO_LEVEL, level);
        // no credits left, so this batch overflows
        repeat (FIFO_DEPTH) begin
            value = llr_t'($random(seed));
            if (level < FIFO_DEPTH) begin
                exp_q.push_back(value);
                level++;
            end
            send_llr(value, LLR_USER_PBCH);
        end
        expect_reg("credit_flow full level", REG_FIFO_LEVEL, level);
        check("credit_flow stalled", LINK_CREDITS, rx_q.size());
        return_credits(LINK_CREDITS);
        auto_credit = 1'b1;
        wait_pbch(exp_q.size(), "credit_flow drain");
        check_stream("credit_flow", exp_q);
        settle_credits();
    endtask

    task automatic test_missed_ssbs();
        repeat (MAX_MISSED_SSBS - 1) ssb_tick();
        expect_reg("missed count", REG_MISSED, MAX_MISSED_SSBS - 1);
        expect_reg("missed still locked", REG_STATE, SYNC_LOCKED);
        ssb_tick();
        expect_reg("missed lost lock", REG_STATE, SYNC_SEARCH);
        check("missed state output", SYNC_SEARCH, sync_state_o);
        expect_reg("missed total", REG_MISSED, MAX_MISSED_SSBS);
    endtask

    task automatic test_cfo_tracking();
        phase_t inc_model;
        phase_t phase_model;
        phase_t est;
        inc_model = '0;
        pulse_pss(2'd1);
        expect_reg("cfo state", REG_STATE, SYNC_PSS_FOUND);
        repeat (CFO_UPDATES) begin
            est       = phase_t'($random(seed));
            inc_model = inc_model - est;
            @(posedge clk_i);
            cfo_valid_i <= 1'b1;
            cfo_inc_i   <= est;
        end
        @(posedge clk_i);
        cfo_valid_i <= 1'b0;
        drive_samples(CFO_SAMPLES);
        phase_model = phase_t'(inc_model * CFO_SAMPLES);
        expect_reg("cfo phase", REG_PHASE, 32'(phase_model));
        expect_reg("cfo sample_id", REG_SAMPLE_ID, samples_total);
        @(posedge clk_i);
        cfo_manual_i <= 1'b1;
        drive_samples(4);
        expect_reg("cfo manual phase", REG_PHASE, 0);
        expect_reg("cfo manual sample_id", REG_SAMPLE_ID, samples_total);
        @(posedge clk_i);
        cfo_manual_i <= 1'b0;
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        seed = 32'h9f8e;
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(negedge clk_i);
        check("reset outputs", 0, {pbch_valid_o, rd_valid_o, sync_state_o});
        test_llr_before_lock();
        test_lock_sequence();
        test_pbch_filter();
        test_credit_flow();
        test_missed_ssbs();
        test_cfo_tracking();
        assert_fails = u_rx_status_top.u_pbch_llr_fifo.u_fifo_props.fail_count
                     + u_rx_status_top.u_rx_sync_ctrl.u_ctrl_props.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- rx_status.f
hdl/rx_pkg.sv
hdl/rx_sync_ctrl.sv
hdl/cfo_phase_tracker.sv
hdl/pbch_llr_fifo.sv
hdl/rx_status_regs.sv
hdl/rx_status_top.sv
verification/rx_status_props.sv
verification/rx_status_tb.sv

//--- Makefile
TOP := rx_status_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wno-fatal -f rx_status.f --top-module rx_status_top
	verilator --lint-only --timing --assert -Wno-fatal -f rx_status.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f rx_status.f \
		--top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
